// File: hw/rsa_pkg.sv
`default_nettype none

package rsa_pkg;

    typedef logic [4:0]  avm_addr_t;    // word address on the bus
    typedef logic [31:0] avm_word_t;
    typedef logic [7:0]  io_byte_t;     // one serial byte

    // register byte offsets of the serial port
    localparam avm_addr_t rx_base     = 5'd0;
    localparam avm_addr_t tx_base     = 5'd4;
    localparam avm_addr_t status_base = 5'd8;

    localparam int rx_ok_bit = 7;       // rx holds a byte
    localparam int tx_ok_bit = 6;       // tx can take a byte

    typedef struct packed {
        avm_addr_t address;
        logic      read;
        logic      write;
    } avm_cmd_t;

    typedef enum logic [2:0] {
        get_n, get_d, get_enc, calc, send_dec
    } wrap_state_e;

    typedef enum logic {poll, xfer} io_phase_e;

    typedef enum logic [1:0] {
        idle, prep, loop, done
    } core_state_e;

endpackage

`default_nettype wire

// File: hw/rsa_mont_mul.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_mont_mul #(
    parameter int bitwidth = 256
) (
    input  wire                 avm_clk,
    input  wire                 avm_rst,
    input  wire                 start,
    input  wire  [bitwidth-1:0] a,
    input  wire  [bitwidth-1:0] b,
    input  wire  [bitwidth-1:0] n,
    output logic                done,
    output logic [bitwidth-1:0] result
);
    typedef logic [$clog2(bitwidth)-1:0] bit_cnt_t;
    typedef logic [bitwidth:0]           acc_t;     // stays below 2n
    typedef logic [bitwidth+1:0]         sum_t;     // acc + b + n before halving

    logic [bitwidth-1:0] a_r;
    logic [bitwidth-1:0] b_r;
    logic [bitwidth-1:0] n_r;
    acc_t                acc_r;
    bit_cnt_t            cnt_r;
    logic                busy_r;
    logic                fin_r;     // final correction cycle
    sum_t                sum_add;
    sum_t                sum_red;
    acc_t                acc_sub;

    always_comb begin
        sum_add = sum_t'(acc_r) + (a_r[0] ? sum_t'(b_r) : '0);
        sum_red = sum_add[0] ? sum_add + sum_t'(n_r) : sum_add;  // force even
        acc_sub = acc_r - acc_t'(n_r);
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy_r <= 1'b0;
            fin_r  <= 1'b0;
            done   <= 1'b0;
            cnt_r  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_r <= 1'b1;
                cnt_r  <= '0;
            end else if (busy_r) begin
                cnt_r <= cnt_r + 1'b1;
                if (cnt_r == bit_cnt_t'(bitwidth - 1)) begin
                    busy_r <= 1'b0;
                    fin_r  <= 1'b1;
                end
            end else if (fin_r) begin
                fin_r <= 1'b0;
                done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            a_r   <= a;
            b_r   <= b;
            n_r   <= n;
            acc_r <= '0;
        end else if (busy_r) begin
            acc_r <= sum_red[bitwidth+1:1];     // divide by two
            a_r   <= a_r >> 1;                  // next bit of a
        end else if (fin_r) begin
            result <= (acc_r >= acc_t'(n_r)) ? acc_sub[bitwidth-1:0] : acc_r[bitwidth-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/rsa_mont_prep.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_mont_prep #(
    parameter int bitwidth = 256
) (
    input  wire                 avm_clk,
    input  wire                 avm_rst,
    input  wire                 start,
    input  wire  [bitwidth-1:0] a,
    input  wire  [bitwidth-1:0] n,
    output logic                done,
    output logic [bitwidth-1:0] result
);
    typedef logic [$clog2(bitwidth+1)-1:0] iter_cnt_t;
    typedef logic [bitwidth:0]             val_t;   // room for one doubling

    val_t                val_r;
    val_t                val_dbl;
    val_t                val_red;
    logic [bitwidth-1:0] n_r;
    iter_cnt_t           cnt_r;
    logic                busy_r;

    // first pass only brings a below n, the other bitwidth passes double
    always_comb begin
        val_dbl = (cnt_r == '0) ? val_r : val_r << 1;
        val_red = (val_dbl >= val_t'(n_r)) ? val_dbl - val_t'(n_r) : val_dbl;
    end

    assign result = val_r[bitwidth-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy_r <= 1'b0;
            done   <= 1'b0;
            cnt_r  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_r <= 1'b1;
                cnt_r  <= '0;
            end else if (busy_r) begin
                cnt_r <= cnt_r + 1'b1;
                if (cnt_r == iter_cnt_t'(bitwidth)) begin
                    busy_r <= 1'b0;
                    done   <= 1'b1;     // val_r final on this edge
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            val_r <= val_t'(a);
            n_r   <= n;
        end else if (busy_r) begin
            val_r <= val_red;
        end
    end

endmodule

`default_nettype wire

// File: hw/rsa_exp_core.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_exp_core #(
    parameter int bitwidth = 256
) (
    input  wire                 avm_clk,
    input  wire                 avm_rst,
    input  wire                 calc_req,
    input  wire  [bitwidth-1:0] n,
    input  wire  [bitwidth-1:0] d,
    input  wire  [bitwidth-1:0] enc,
    output logic                calc_ack,
    output logic [bitwidth-1:0] dec
);
    typedef logic [$clog2(bitwidth)-1:0] step_cnt_t;

    rsa_pkg::core_state_e state_r;
    logic [bitwidth-1:0]  n_r;
    logic [bitwidth-1:0]  d_r;          // shifts right, bit 0 is current
    logic [bitwidth-1:0]  enc_r;
    logic [bitwidth-1:0]  base_r;       // montgomery domain
    logic [bitwidth-1:0]  res_r;        // plain domain, starts at 1
    step_cnt_t            step_r;
    logic                 prep_start_r;
    logic                 step_start_r;
    logic                 mul_start;
    logic                 prep_done;
    logic                 sq_done;
    logic                 mul_done;
    logic [bitwidth-1:0]  prep_result;
    logic [bitwidth-1:0]  sq_result;
    logic [bitwidth-1:0]  mul_result;

    assign dec       = res_r;
    assign mul_start = step_start_r & d_r[0];   // multiply only on set bits

    rsa_mont_prep #(.bitwidth(bitwidth)) u_prep (
        .avm_clk(avm_clk),
        .avm_rst(avm_rst),
        .start  (prep_start_r),
        .a      (enc_r),
        .n      (n_r),
        .done   (prep_done),
        .result (prep_result)
    );

    rsa_mont_mul #(.bitwidth(bitwidth)) u_square (
        .avm_clk(avm_clk),
        .avm_rst(avm_rst),
        .start  (step_start_r),
        .a      (base_r),
        .b      (base_r),
        .n      (n_r),
        .done   (sq_done),
        .result (sq_result)
    );

    // res * base * R^-1 keeps res out of the montgomery domain
    rsa_mont_mul #(.bitwidth(bitwidth)) u_multiply (
        .avm_clk(avm_clk),
        .avm_rst(avm_rst),
        .start  (mul_start),
        .a      (res_r),
        .b      (base_r),
        .n      (n_r),
        .done   (mul_done),
        .result (mul_result)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r      <= rsa_pkg::idle;
            step_r       <= '0;
            prep_start_r <= 1'b0;
            step_start_r <= 1'b0;
            calc_ack     <= 1'b0;
        end else begin
            prep_start_r <= 1'b0;
            step_start_r <= 1'b0;
            case (state_r)
                rsa_pkg::idle: if (calc_req) begin
                    prep_start_r <= 1'b1;
                    state_r      <= rsa_pkg::prep;
                end
                rsa_pkg::prep: if (prep_done) begin
                    step_r       <= '0;
                    step_start_r <= 1'b1;
                    state_r      <= rsa_pkg::loop;
                end
                rsa_pkg::loop: if (sq_done) begin
                    if (step_r == step_cnt_t'(bitwidth - 1)) begin
                        calc_ack <= 1'b1;       // dec already settled
                        state_r  <= rsa_pkg::done;
                    end else begin
                        step_r       <= step_r + 1'b1;
                        step_start_r <= 1'b1;
                    end
                end
                default: if (!calc_req) begin
                    calc_ack <= 1'b0;
                    state_r  <= rsa_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state_r == rsa_pkg::idle && calc_req) begin
            n_r   <= n;
            d_r   <= d;
            enc_r <= enc;
        end else if (prep_done) begin
            base_r <= prep_result;
            res_r  <= bitwidth'(1);
        end else if (sq_done) begin
            base_r <= sq_result;
            d_r    <= d_r >> 1;
        end
        if (mul_done)
            res_r <= mul_result;  // lands with sq_done
    end

endmodule

`default_nettype wire

// File: hw/rsa_avm_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_avm_wrapper #(
    parameter int bitwidth = 256
) (
    input  wire                     avm_clk,
    input  wire                     avm_rst,
    output rsa_pkg::avm_addr_t      avm_address,
    output logic                    avm_read,
    input  wire rsa_pkg::avm_word_t avm_readdata,
    output logic                    avm_write,
    output rsa_pkg::avm_word_t      avm_writedata,
    input  wire                     avm_waitrequest,
    output logic                    calc_req,
    output logic [bitwidth-1:0]     n,
    output logic [bitwidth-1:0]     d,
    output logic [bitwidth-1:0]     enc,
    input  wire                     calc_ack,
    input  wire  [bitwidth-1:0]     dec
);
    typedef logic [$clog2(bitwidth/8)-1:0] byte_cnt_t;

    localparam rsa_pkg::avm_cmd_t poll_cmd =
        '{address: rsa_pkg::status_base, read: 1'b1, write: 1'b0};
    localparam rsa_pkg::avm_cmd_t rd_cmd =
        '{address: rsa_pkg::rx_base, read: 1'b1, write: 1'b0};
    localparam rsa_pkg::avm_cmd_t wr_cmd =
        '{address: rsa_pkg::tx_base, read: 1'b0, write: 1'b1};
    localparam rsa_pkg::avm_cmd_t idle_cmd =
        '{address: rsa_pkg::status_base, read: 1'b0, write: 1'b0};

    rsa_pkg::wrap_state_e state_r;
    rsa_pkg::wrap_state_e next_state;
    rsa_pkg::io_phase_e   phase_r;
    rsa_pkg::avm_cmd_t    cmd_r;
    byte_cnt_t            byte_cnt_r;
    logic                 calc_req_r;
    logic [bitwidth-1:0]  n_r;
    logic [bitwidth-1:0]  d_r;
    logic [bitwidth-1:0]  enc_r;
    logic [bitwidth-1:0]  dec_r;
    rsa_pkg::io_byte_t    rx_byte;
    rsa_pkg::io_byte_t    tx_byte;
    logic                 get_state;
    logic                 ok_bit;
    logic                 xfer_done;
    logic                 last_byte;

    // msb first, new byte enters at the bottom
    function automatic logic [bitwidth-1:0] shift_in(input logic [bitwidth-1:0] v,
                                                     input rsa_pkg::io_byte_t b);
        return {v[bitwidth-9:0], b};
    endfunction

    assign get_state = state_r inside {rsa_pkg::get_n, rsa_pkg::get_d, rsa_pkg::get_enc};
    assign ok_bit    = get_state ? avm_readdata[rsa_pkg::rx_ok_bit]
                                 : avm_readdata[rsa_pkg::tx_ok_bit];
    assign xfer_done = (phase_r == rsa_pkg::xfer) && !avm_waitrequest;
    assign last_byte = get_state ? byte_cnt_r == byte_cnt_t'(bitwidth/8 - 1)
                                 : byte_cnt_r == byte_cnt_t'(bitwidth/8 - 2);  // top byte dropped

    assign rx_byte       = avm_readdata[7:0];
    assign tx_byte       = dec_r[bitwidth-9 -: 8];
    assign avm_address   = cmd_r.address;
    assign avm_read      = cmd_r.read;
    assign avm_write     = cmd_r.write;
    assign avm_writedata = rsa_pkg::avm_word_t'(tx_byte);
    assign calc_req      = calc_req_r;
    assign n             = n_r;
    assign d             = d_r;
    assign enc           = enc_r;

    always_comb begin
        case (state_r)
            rsa_pkg::get_n:   next_state = rsa_pkg::get_d;
            rsa_pkg::get_d:   next_state = rsa_pkg::get_enc;
            rsa_pkg::get_enc: next_state = rsa_pkg::calc;
            default:          next_state = rsa_pkg::get_enc;   // key is kept
        endcase
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r    <= rsa_pkg::get_n;
            phase_r    <= rsa_pkg::poll;
            cmd_r      <= poll_cmd;
            byte_cnt_r <= '0;
            calc_req_r <= 1'b0;
        end else if (state_r != rsa_pkg::calc) begin
            if (phase_r == rsa_pkg::poll) begin
                if (!avm_waitrequest && ok_bit) begin
                    cmd_r   <= get_state ? rd_cmd : wr_cmd;
                    phase_r <= rsa_pkg::xfer;
                end
            end else if (!avm_waitrequest) begin
                phase_r    <= rsa_pkg::poll;
                cmd_r      <= poll_cmd;
                byte_cnt_r <= byte_cnt_r + 1'b1;
                if (last_byte) begin
                    byte_cnt_r <= '0;
                    state_r    <= next_state;
                    if (state_r == rsa_pkg::get_enc)
                        cmd_r <= idle_cmd;  // bus quiet while the core runs
                end
            end
        end else if (!calc_req_r) begin
            calc_req_r <= !calc_ack;        // wait for the old ack to clear
        end else if (calc_ack) begin
            calc_req_r <= 1'b0;
            state_r    <= rsa_pkg::send_dec;
            cmd_r      <= poll_cmd;
        end
    end

    always_ff @(posedge avm_clk) begin
        if (xfer_done && state_r == rsa_pkg::get_n)
            n_r <= shift_in(n_r, rx_byte);
        if (xfer_done && state_r == rsa_pkg::get_d)
            d_r <= shift_in(d_r, rx_byte);
        if (xfer_done && state_r == rsa_pkg::get_enc)
            enc_r <= shift_in(enc_r, rx_byte);
        if (calc_req_r && calc_ack)
            dec_r <= dec;
        else if (xfer_done && state_r == rsa_pkg::send_dec)
            dec_r <= dec_r << 8;            // next byte down
    end

endmodule

`default_nettype wire

// File: hw/rsa_top.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_top #(
    parameter int bitwidth = 256
) (
    input  wire                     avm_clk,
    input  wire                     avm_rst,
    output rsa_pkg::avm_addr_t      avm_address,
    output logic                    avm_read,
    input  wire rsa_pkg::avm_word_t avm_readdata,
    output logic                    avm_write,
    output rsa_pkg::avm_word_t      avm_writedata,
    input  wire                     avm_waitrequest
);
    // req/ack link between bus side and core
    logic                calc_req;
    logic                calc_ack;
    logic [bitwidth-1:0] n;
    logic [bitwidth-1:0] d;
    logic [bitwidth-1:0] enc;
    logic [bitwidth-1:0] dec;

    rsa_avm_wrapper #(.bitwidth(bitwidth)) u_wrapper (
        .avm_clk        (avm_clk),
        .avm_rst        (avm_rst),
        .avm_address    (avm_address),
        .avm_read       (avm_read),
        .avm_readdata   (avm_readdata),
        .avm_write      (avm_write),
        .avm_writedata  (avm_writedata),
        .avm_waitrequest(avm_waitrequest),
        .calc_req       (calc_req),
        .n              (n),
        .d              (d),
        .enc            (enc),
        .calc_ack       (calc_ack),
        .dec            (dec)
    );

    rsa_exp_core #(.bitwidth(bitwidth)) u_core (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .calc_req(calc_req),
        .n       (n),
        .d       (d),
        .enc     (enc),
        .calc_ack(calc_ack),
        .dec     (dec)
    );

endmodule

`default_nettype wire

// File: test/tb_rsa_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rsa_top;
    localparam int bitwidth  = 32;
    localparam int nbytes    = bitwidth / 8;
    localparam int max_pairs = 7;
    localparam int num_words = 3 + 2 * max_pairs;   // n, d, count, then pairs

    logic                avm_clk;
    logic                avm_rst;
    rsa_pkg::avm_addr_t  avm_address;
    logic                avm_read;
    rsa_pkg::avm_word_t  avm_readdata;
    logic                avm_write;
    rsa_pkg::avm_word_t  avm_writedata;
    logic                avm_waitrequest;

    rsa_pkg::avm_word_t  testdata [0:num_words-1];
    rsa_pkg::io_byte_t   rx_q [$];      // bytes the serial port still holds
    int                  num_pairs;
    int                  pair_idx;
    int                  tx_count;      // result bytes seen so far
    int                  rx_reads;      // data reads since the last result
    logic [bitwidth-1:0] plain;
    logic [31:0]         lfsr;
    logic                data_loaded;
    logic                all_done;
    logic                tx_idle_seen;
    logic                first_seen;
    logic                stalled;
    logic                last_rx_ok;
    logic                last_tx_ok;
    rsa_pkg::avm_cmd_t   held_cmd;
    rsa_pkg::avm_word_t  held_data;

    rsa_top #(.bitwidth(bitwidth)) dut (
        .avm_clk        (avm_clk),
        .avm_rst        (avm_rst),
        .avm_address    (avm_address),
        .avm_read       (avm_read),
        .avm_readdata   (avm_readdata),
        .avm_write      (avm_write),
        .avm_writedata  (avm_writedata),
        .avm_waitrequest(avm_waitrequest)
    );

    always #2 avm_clk = ~avm_clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string sig_name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Fail %s got 0x%08h expected 0x%08h", sig_name, got, expected);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    // msb first, as the serial line delivers it
    task automatic push_operand(input logic [bitwidth-1:0] value);
        for (int i = nbytes - 1; i >= 0; i--)
            rx_q.push_back(value[8*i +: 8]);
    endtask

    task automatic drive_readdata();
        rsa_pkg::avm_word_t word;
        word = '0;
        if (avm_address == rsa_pkg::status_base) begin
            lfsr = lfsr_step(lfsr);
            word[rsa_pkg::rx_ok_bit] = lfsr[0] && (rx_q.size() > 0);
            lfsr = lfsr_step(lfsr);
            word[rsa_pkg::tx_ok_bit] = lfsr[0];
        end else if (avm_address == rsa_pkg::rx_base && rx_q.size() > 0) begin
            word[7:0] = rx_q[0];
        end
        avm_readdata <= word;
    endtask

    task automatic take_result_byte();
        int exp_reads;
        exp_reads = (pair_idx == 0) ? 3 * nbytes : nbytes;   // key only once
        if (tx_count == 0) begin
            assert (pair_idx < num_pairs)
                else report_problem("tx_base write after the last result");
            assert (rx_reads == exp_reads)
                else report_mismatch("rx_reads", rx_reads, exp_reads);
            rx_reads = 0;
        end
        assert (avm_writedata[31:8] == '0)
            else report_mismatch("avm_writedata", avm_writedata, {24'h0, avm_writedata[7:0]});
        plain = {plain[bitwidth-9:0], avm_writedata[7:0]};
        tx_count++;
        if (tx_count == nbytes - 1) begin    // top byte never sent
            assert (plain == testdata[4 + 2 * pair_idx])
                else report_mismatch("plaintext", plain, testdata[4 + 2 * pair_idx]);
            $display("result %0d matched 0x%08h", pair_idx, plain);
            pair_idx++;
            tx_count = 0;
            plain    = '0;
            if (pair_idx < num_pairs)
                push_operand(testdata[3 + 2 * pair_idx]);
            else
                all_done = 1'b1;
        end
    endtask

    task automatic finish_transfer();
        if (avm_read && avm_address == rsa_pkg::status_base) begin
            if (all_done && last_tx_ok)
                tx_idle_seen = 1'b1;    // tx_ok left unused after the last result
            last_rx_ok = avm_readdata[rsa_pkg::rx_ok_bit];
            last_tx_ok = avm_readdata[rsa_pkg::tx_ok_bit];
        end else if (avm_read && avm_address == rsa_pkg::rx_base) begin
            assert (last_rx_ok)
                else report_problem("rx_base read without a status read showing rx_ok");
            rx_q.delete(0);
            last_rx_ok = 1'b0;
            rx_reads++;
        end else if (avm_write && avm_address == rsa_pkg::tx_base) begin
            assert (last_tx_ok)
                else report_problem("tx_base write without a status read showing tx_ok");
            last_tx_ok = 1'b0;
            take_result_byte();
        end else begin
            report_problem($sformatf("bus access to unexpected address 0x%h", avm_address));
        end
    endtask

    // serial port register block
    always @(posedge avm_clk) begin
        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
            avm_readdata    <= '0;
            stalled = 1'b0;
        end else begin
            if (!first_seen) begin
                assert (avm_read && !avm_write)
                    else report_problem("first command after reset is not a read");
                assert (avm_address == rsa_pkg::status_base)
                    else report_mismatch("avm_address", avm_address, rsa_pkg::status_base);
                first_seen = 1'b1;
            end
            if (stalled) begin  // held since the last edge
                assert (avm_address == held_cmd.address)
                    else report_mismatch("avm_address", avm_address, held_cmd.address);
                assert (avm_read == held_cmd.read)
                    else report_mismatch("avm_read", avm_read, held_cmd.read);
                assert (avm_write == held_cmd.write)
                    else report_mismatch("avm_write", avm_write, held_cmd.write);
                assert (avm_writedata === held_data)
                    else report_mismatch("avm_writedata", avm_writedata, held_data);
            end
            assert (!(avm_read && avm_write))
                else report_problem("read and write asserted in the same cycle");
            stalled = 1'b0;
            if ((avm_read || avm_write) && !avm_waitrequest) begin
                finish_transfer();
                avm_waitrequest <= 1'b1;    // next command not seen yet
                avm_readdata    <= '0;
            end else if (avm_read || avm_write) begin
                held_cmd  = '{address: avm_address, read: avm_read, write: avm_write};
                held_data = avm_writedata;
                stalled   = 1'b1;
                lfsr = lfsr_step(lfsr);
                avm_waitrequest <= lfsr[0];
                drive_readdata();
            end else begin
                avm_waitrequest <= 1'b1;    // bus idle while the core runs
            end
        end
    end

    initial begin
        avm_clk         = 1'b0;
        avm_rst         = 1'b1;
        avm_readdata    = '0;
        avm_waitrequest = 1'b1;
        lfsr            = 32'h3772;
        pair_idx        = 0;
        tx_count        = 0;
        rx_reads        = 0;
        plain           = '0;
        all_done        = 1'b0;
        tx_idle_seen    = 1'b0;
        first_seen      = 1'b0;
        stalled         = 1'b0;
        last_rx_ok      = 1'b0;
        last_tx_ok      = 1'b0;
        data_loaded     = 1'b0;
        $readmemh("test/rsa_testdata.txt", testdata);
        num_pairs = testdata[2];
        assert (num_pairs >= 1 && num_pairs <= max_pairs)
            else report_problem("testdata holds no usable number of pairs");
        push_operand(testdata[0]);  // n
        push_operand(testdata[1]);  // d
        push_operand(testdata[3]);
        data_loaded = 1'b1;
        repeat (16) @(posedge avm_clk);
        avm_rst <= 1'b0;
        wait (tx_idle_seen);
        $display("No errors");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (data_loaded);
        limit = num_pairs * (bitwidth + 3) * (bitwidth + 3) * 8;
        repeat (limit) @(posedge avm_clk);
        $display("Timeout after %0d cycles, not all results were written", limit);
        stop_with_failure();
    end

endmodule

`default_nettype wire

// File: test/rsa_testdata.txt
// n, d and the number of pairs, then one pair per line: ciphertext, expected plaintext
// key for bitwidth 32, n = 3557 * 2579, plaintexts below 2^24
008bf9ff
005d415b
00000007
00000008 00000002
0014de4f 0000006f
008b4d71 000000d1
0001586d 000003e8
004822d3 00010001
008bf9fe 008bf9fe
00000001 00000001

// File: tb.f
hw/rsa_pkg.sv
hw/rsa_mont_mul.sv
hw/rsa_mont_prep.sv
hw/rsa_exp_core.sv
hw/rsa_avm_wrapper.sv
hw/rsa_top.sv
test/tb_rsa_top.sv

// File: Bender.yml
package:
  name: rsa_avm

sources:
  - files:
      - hw/rsa_pkg.sv
      - hw/rsa_mont_mul.sv
      - hw/rsa_mont_prep.sv
      - hw/rsa_exp_core.sv
      - hw/rsa_avm_wrapper.sv
      - hw/rsa_top.sv
  - target: test
    files:
      - test/tb_rsa_top.sv
